// File: common/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// address and line geometry
`define ICACHE_ADDR_W    32
`define ICACHE_INDEX_W   6   // 64 sets
`define ICACHE_OFFSET_W  6   // 64-byte lines

// widths of one line and of one fetch response
`define ICACHE_LINE_W    512
`define ICACHE_FETCH_W   64

// associativity
`define ICACHE_WAYS      2

`endif

// File: common/icache_pkg.sv
`default_nettype none
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_ADDR_W-`ICACHE_INDEX_W-`ICACHE_OFFSET_W-1:0] tag_t;
    typedef logic [`ICACHE_LINE_W-1:0] line_t;
    typedef logic [`ICACHE_FETCH_W-1:0] fetch_t;

    // one tag array entry, valid bit on top
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef enum logic [1:0] {
        FETCH          = 2'd0,
        FETCH_UNCACHED = 2'd1,
        IDX_INV        = 2'd2,  // way picked by addr[0]
        HIT_INV        = 2'd3
    } icache_op_e;

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        icache_op_e                op;
    } fetch_req_t;

    typedef struct packed {
        fetch_t                    data;
        logic                      adef;  // address not word aligned
        logic [`ICACHE_ADDR_W-1:0] addr;
    } fetch_resp_t;

    // line aligned for cached fetches, 8-byte aligned when uncached
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
    } mem_req_t;

endpackage

`default_nettype wire

// File: icache/icache_sram.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_sram #(
    parameter type entry_t = logic
) (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire icache_pkg::index_t i_rd_index,
    output entry_t                  o_rd_entry,
    input  wire                     i_we,
    input  wire icache_pkg::index_t i_wr_index,
    input  wire entry_t             i_wr_entry
);
    localparam int DEPTH = 1 << `ICACHE_INDEX_W;

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we)
            mem[i_wr_index] <= i_wr_entry;
    end

    // registered read, new data wins on an address clash
    always_ff @(posedge clk) begin
        if (!rstn)
            o_rd_entry <= '0;
        else if (i_we && (i_wr_index == i_rd_index))
            o_rd_entry <= i_wr_entry;
        else
            o_rd_entry <= mem[i_rd_index];
    end

endmodule

`default_nettype wire

// File: icache/icache_hit_check.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_hit_check (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire icache_pkg::tagv_t   i_tag_way0,
    input  wire icache_pkg::tagv_t   i_tag_way1,
    input  wire icache_pkg::tag_t    i_req_tag,
    input  wire icache_pkg::index_t  i_index,
    output logic [`ICACHE_WAYS-1:0]  o_hit,
    output logic                     o_victim,
    input  wire                      i_lru_we,
    input  wire                      i_lru_way
);
    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic [SETS-1:0] mru;  // 1 when way 1 was used last

    assign o_hit[0] = i_tag_way0.valid && (i_tag_way0.tag == i_req_tag);
    assign o_hit[1] = i_tag_way1.valid && (i_tag_way1.tag == i_req_tag);

    // replace the way not used last
    assign o_victim = !mru[i_index];

    always_ff @(posedge clk) begin
        if (!rstn)
            mru <= '0;   // victim starts as way 1
        else if (i_lru_we)
            mru[i_index] <= i_lru_way;
    end

    // a refill only fills a missing line, so a set never holds a tag twice
    a_one_hot_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        !(o_hit[0] && o_hit[1])
    );

endmodule

`default_nettype wire

// File: icache/icache_read_align.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_read_align (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire icache_pkg::line_t  i_line_way0,
    input  wire icache_pkg::line_t  i_line_way1,
    input  wire                     i_hit_way,
    input  wire icache_pkg::line_t  i_mem_data,
    input  wire                     i_ret_load,
    input  wire                     i_from_ret,
    input  wire                     i_data_clr,
    input  wire [2:0]               i_chunk_sel,
    output icache_pkg::fetch_t      o_data
);
    import icache_pkg::*;

    line_t ret_buf;   // last line from memory
    line_t line_sel;

    always_ff @(posedge clk) begin
        if (!rstn)
            ret_buf <= '0;
        else if (i_ret_load)
            ret_buf <= i_mem_data;
    end

    always_comb begin
        if (i_from_ret)
            line_sel = ret_buf;
        else if (i_hit_way)
            line_sel = i_line_way1;
        else
            line_sel = i_line_way0;
    end

    // cache operations answer with zero data
    assign o_data = i_data_clr ? '0 :
                    line_sel[i_chunk_sel * `ICACHE_FETCH_W +: `ICACHE_FETCH_W];

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_ctrl (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             i_req_valid,
    output logic                            o_req_ready,
    input  wire icache_pkg::fetch_req_t     i_req,
    output logic                            o_resp_valid,
    output logic                            o_resp_adef,
    output logic [`ICACHE_ADDR_W-1:0]       o_resp_addr,
    output logic                            o_mem_valid,
    input  wire                             i_mem_ready,
    output icache_pkg::mem_req_t            o_mem_req,
    output icache_pkg::index_t              o_rd_index,
    output icache_pkg::index_t              o_wr_index,
    output logic [`ICACHE_WAYS-1:0]         o_tag_we,
    output logic [`ICACHE_WAYS-1:0]         o_data_we,
    output icache_pkg::tagv_t               o_tag_wdata,
    input  wire  [`ICACHE_WAYS-1:0]         i_hit,
    input  wire                             i_victim,
    output logic                            o_lru_we,
    output logic                            o_lru_way,
    output logic                            o_ret_load,
    output logic                            o_from_ret,
    output logic                            o_data_clr
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_SWEEP,   // clearing valid bits after reset
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_REFILL,
        S_CACOP
    } state_e;

    state_e                  state;
    state_e                  state_nxt;
    fetch_req_t              req_buf;
    index_t                  sweep_idx;
    index_t                  buf_index;
    logic                    accept;
    logic                    buf_fetch;
    logic                    buf_cached;
    logic                    buf_adef;
    logic [`ICACHE_WAYS-1:0] victim_oh;
    logic [`ICACHE_WAYS-1:0] inv_oh;

    assign accept     = i_req_valid && o_req_ready;
    assign buf_index  = req_buf.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign buf_cached = req_buf.op == FETCH;
    assign buf_fetch  = buf_cached || (req_buf.op == FETCH_UNCACHED);
    assign buf_adef   = buf_fetch && (req_buf.addr[1:0] != 2'b00);
    assign victim_oh  = `ICACHE_WAYS'(1) << i_victim;
    assign inv_oh     = (req_buf.op == IDX_INV) ? (`ICACHE_WAYS'(1) << req_buf.addr[0]) : i_hit;

    assign o_resp_adef = buf_adef;
    assign o_resp_addr = req_buf.addr;

    // uncached reads fetch only the 8-byte chunk
    assign o_mem_req.addr = buf_cached ?
        {req_buf.addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], `ICACHE_OFFSET_W'(0)} :
        {req_buf.addr[`ICACHE_ADDR_W-1:3], 3'b000};

    // set only for a refill write while invalidates and the sweep clear it
    assign o_tag_wdata.valid = (state == S_LOOKUP) || (state == S_MISS);
    assign o_tag_wdata.tag   = req_buf.addr[`ICACHE_ADDR_W-1 -: $bits(tag_t)];

    assign o_wr_index = (state == S_SWEEP) ? sweep_idx : buf_index;

    always_comb begin
        if (accept)
            o_rd_index = i_req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        else if (state == S_SWEEP)
            o_rd_index = sweep_idx;  // keeps tag outputs known
        else
            o_rd_index = buf_index;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= S_SWEEP;
            sweep_idx <= '0;
        end else begin
            state <= state_nxt;
            if (state == S_SWEEP)
                sweep_idx <= sweep_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            req_buf <= '0;
        else if (accept)
            req_buf <= i_req;
    end

    always_comb begin
        state_nxt    = state;
        o_req_ready  = 1'b0;
        o_resp_valid = 1'b0;
        o_mem_valid  = 1'b0;
        o_ret_load   = 1'b0;
        o_from_ret   = 1'b0;
        o_data_clr   = 1'b0;
        o_lru_we     = 1'b0;
        o_lru_way    = 1'b0;
        o_tag_we     = '0;
        o_data_we    = '0;
        case (state)
            S_SWEEP: begin
                o_tag_we = '1;
                if (sweep_idx == '1)
                    state_nxt = S_IDLE;
            end
            S_IDLE: begin
                o_req_ready = 1'b1;
            end
            S_LOOKUP: begin
                if (buf_adef || (buf_cached && |i_hit)) begin
                    o_resp_valid = 1'b1;
                    o_req_ready  = 1'b1;   // lets hits stream
                    o_lru_we     = !buf_adef;
                    o_lru_way    = i_hit[1];
                end else if (buf_fetch) begin
                    o_mem_valid = 1'b1;    // miss or uncached
                end else begin
                    state_nxt = S_CACOP;
                end
            end
            S_MISS: begin
                o_mem_valid = 1'b1;
            end
            S_REFILL: begin
                o_resp_valid = 1'b1;
                o_req_ready  = 1'b1;
                o_from_ret   = 1'b1;
                o_lru_we     = buf_cached;
                o_lru_way    = i_victim;   // the way just filled
            end
            S_CACOP: begin
                o_resp_valid = 1'b1;
                o_req_ready  = 1'b1;
                o_data_clr   = 1'b1;
                o_tag_we     = inv_oh;
            end
            default: state_nxt = S_IDLE;
        endcase

        // the victim way fills on the edge the line arrives
        if (o_mem_valid) begin
            o_ret_load = i_mem_ready;
            if (buf_cached && i_mem_ready) begin
                o_tag_we  = victim_oh;
                o_data_we = victim_oh;
            end
            state_nxt = i_mem_ready ? S_REFILL : S_MISS;
        end

        if (o_req_ready)
            state_nxt = i_req_valid ? S_LOOKUP : S_IDLE;
    end

    // memory request is held until taken
    a_mem_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_req)
    );

    // no response while a line is awaited
    a_no_resp_in_miss: assert property (
        @(posedge clk) disable iff (!rstn)
        o_mem_valid |-> !o_resp_valid
    );

endmodule

`default_nettype wire

// File: rtl/icache_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_top (
    input  wire                           clk,
    input  wire                           rstn,
    input  wire                           i_req_valid,
    output logic                          o_req_ready,
    input  wire icache_pkg::fetch_req_t   i_req,
    output logic                          o_resp_valid,
    output icache_pkg::fetch_resp_t       o_resp,
    output logic                          o_mem_valid,
    input  wire                           i_mem_ready,
    output icache_pkg::mem_req_t          o_mem_req,
    input  wire icache_pkg::line_t        i_mem_data
);
    import icache_pkg::*;

    index_t                  rd_index;
    index_t                  wr_index;
    logic [`ICACHE_WAYS-1:0] tag_we;
    logic [`ICACHE_WAYS-1:0] data_we;
    logic [`ICACHE_WAYS-1:0] hit;
    tagv_t                   tag_wdata;
    tagv_t                   tag_rd [`ICACHE_WAYS];
    line_t                   line_rd [`ICACHE_WAYS];
    logic                    victim;
    logic                    lru_we;
    logic                    lru_way;
    logic                    ret_load;
    logic                    from_ret;
    logic                    data_clr;
    logic                    resp_adef;
    logic [`ICACHE_ADDR_W-1:0] resp_addr;
    fetch_t                  align_data;

    assign o_resp = '{data: align_data, adef: resp_adef, addr: resp_addr};

    icache_ctrl u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req        (i_req),
        .o_resp_valid (o_resp_valid),
        .o_resp_adef  (resp_adef),
        .o_resp_addr  (resp_addr),
        .o_mem_valid  (o_mem_valid),
        .i_mem_ready  (i_mem_ready),
        .o_mem_req    (o_mem_req),
        .o_rd_index   (rd_index),
        .o_wr_index   (wr_index),
        .o_tag_we     (tag_we),
        .o_data_we    (data_we),
        .o_tag_wdata  (tag_wdata),
        .i_hit        (hit),
        .i_victim     (victim),
        .o_lru_we     (lru_we),
        .o_lru_way    (lru_way),
        .o_ret_load   (ret_load),
        .o_from_ret   (from_ret),
        .o_data_clr   (data_clr)
    );

    // tag and data array per way, refill data straight from memory
    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        icache_sram #(.entry_t(tagv_t)) u_tag (
            .clk        (clk),
            .rstn       (rstn),
            .i_rd_index (rd_index),
            .o_rd_entry (tag_rd[w]),
            .i_we       (tag_we[w]),
            .i_wr_index (wr_index),
            .i_wr_entry (tag_wdata)
        );
        icache_sram #(.entry_t(line_t)) u_data (
            .clk        (clk),
            .rstn       (rstn),
            .i_rd_index (rd_index),
            .o_rd_entry (line_rd[w]),
            .i_we       (data_we[w]),
            .i_wr_index (wr_index),
            .i_wr_entry (i_mem_data)
        );
    end

    icache_hit_check u_hit_check (
        .clk        (clk),
        .rstn       (rstn),
        .i_tag_way0 (tag_rd[0]),
        .i_tag_way1 (tag_rd[1]),
        .i_req_tag  (tag_wdata.tag),
        .i_index    (wr_index),
        .o_hit      (hit),
        .o_victim   (victim),
        .i_lru_we   (lru_we),
        .i_lru_way  (lru_way)
    );

    icache_read_align u_read_align (
        .clk         (clk),
        .rstn        (rstn),
        .i_line_way0 (line_rd[0]),
        .i_line_way1 (line_rd[1]),
        .i_hit_way   (hit[1]),
        .i_mem_data  (i_mem_data),
        .i_ret_load  (ret_load),
        .i_from_ret  (from_ret),
        .i_data_clr  (data_clr),
        .i_chunk_sel (resp_addr[`ICACHE_OFFSET_W-1:3]),
        .o_data      (align_data)
    );

endmodule

`default_nettype wire

// File: dv/tb_icache_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module tb_icache_mem (
    input  wire                       clk,
    input  wire                       i_mem_valid,
    output logic                      o_mem_ready,
    input  wire icache_pkg::mem_req_t i_mem_req,
    output icache_pkg::line_t         o_mem_data
);
    import icache_pkg::*;

    localparam logic [31:0] FILL_KEY = 32'h5a3c_96e1;

    logic [31:0] ovr_addr [16];   // lines written by the tests
    line_t       ovr_data [16];
    int          n_ovr = 0;
    int          req_count = 0;
    int          wait_cyc;
    integer      seed = 38;

    // default word is its word address xor a key, later writes win
    function automatic line_t line_at(input logic [31:0] addr);
        logic [31:0] base;
        line_t       line;
        int          w;
        base = {addr[31:`ICACHE_OFFSET_W], `ICACHE_OFFSET_W'(0)};
        for (w = 0; w < `ICACHE_LINE_W / 32; w++)
            line[w * 32 +: 32] = ((base + w * 4) >> 2) ^ FILL_KEY;
        for (w = 0; w < n_ovr; w++)
            if (ovr_addr[w] == base)
                line = ovr_data[w];
        return line;
    endfunction

    task automatic write_line(input logic [31:0] addr, input line_t data);
        ovr_addr[n_ovr] = {addr[31:`ICACHE_OFFSET_W], `ICACHE_OFFSET_W'(0)};
        ovr_data[n_ovr] = data;
        n_ovr++;
    endtask

    // ready after 1 to 4 cycles, uncached chunks sit at their natural offset
    initial begin
        o_mem_ready = 1'b0;
        o_mem_data  = '0;
        forever begin
            @(negedge clk);
            o_mem_ready = 1'b0;
            if (i_mem_valid) begin
                req_count++;
                wait_cyc = 1 + ({$random(seed)} % 4);
                repeat (wait_cyc - 1) @(negedge clk);
                o_mem_data  = line_at(i_mem_req.addr);
                o_mem_ready = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module tb_icache;
    import icache_pkg::*;

    logic        clk;
    logic        rstn;
    logic        i_req_valid;
    logic        o_req_ready;
    fetch_req_t  i_req;
    logic        o_resp_valid;
    fetch_resp_t o_resp;
    logic        o_mem_valid;
    logic        i_mem_ready;
    mem_req_t    o_mem_req;
    line_t       i_mem_data;
    int          cycle = 0;
    int          n_issued = 0;
    int          n_mismatch = 0;
    int          n_other = 0;
    int          last_acc = 0;   // cycle of the last acceptance
    int          mem_rdy_cyc = 0;
    logic [31:0] mem_addr = '0;  // address of the last line taken from memory
    fetch_resp_t resp_q[$];
    int          resp_cyc_q[$];

    icache_top i_dut (.*);

    tb_icache_mem u_mem (
        .clk         (clk),
        .i_mem_valid (o_mem_valid),
        .o_mem_ready (i_mem_ready),
        .i_mem_req   (o_mem_req),
        .o_mem_data  (i_mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (rstn && o_resp_valid) begin
            resp_q.push_back(o_resp);
            resp_cyc_q.push_back(cycle);
        end
        if (rstn && o_mem_valid && i_mem_ready) begin
            mem_addr    = o_mem_req.addr;
            mem_rdy_cyc = cycle;
        end
    end

    initial begin
        wait (cycle > 40 * n_issued + 200);
        $display("timeout at cycle %0d, the DUT stopped accepting or answering", cycle);
        $display("errors: %0d value mismatches, %0d other failures", n_mismatch, n_other);
        $display("tests failed");
        $finish;
    end

    task automatic check_data(input string name, input fetch_t exp, input fetch_t act);
        if (act !== exp) begin
            n_mismatch++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_adef(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            n_mismatch++;
            $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [`ICACHE_ADDR_W-1:0] exp,
                              input logic [`ICACHE_ADDR_W-1:0] act);
        if (act !== exp) begin
            n_mismatch++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            n_mismatch++;
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    function automatic fetch_t chunk_of(input line_t line, input logic [31:0] addr);
        return line[addr[5:3] * `ICACHE_FETCH_W +: `ICACHE_FETCH_W];
    endfunction

    // leaves valid high so the next call can stream
    task automatic send(input logic [31:0] addr, input icache_op_e op);
        @(negedge clk);
        i_req_valid = 1'b1;
        i_req.addr  = addr;
        i_req.op    = op;
        @(posedge clk);
        while (!o_req_ready) @(posedge clk);
        last_acc = cycle;
        n_issued++;
    endtask

    task automatic take_resp(output fetch_resp_t r, output int cyc);
        while (resp_q.size() == 0) @(negedge clk);
        r   = resp_q.pop_front();
        cyc = resp_cyc_q.pop_front();
    endtask

    // a negative latency marks a miss, answered one cycle after the line
    task automatic fetch_check(input logic [31:0] addr, input icache_op_e op,
                               input fetch_t exp_data, input int exp_lat);
        fetch_resp_t r;
        int          cyc;
        logic        exp_adef;
        exp_adef = (op == FETCH || op == FETCH_UNCACHED) && addr[1:0] != 2'b00;
        send(addr, op);
        @(negedge clk);
        i_req_valid = 1'b0;
        take_resp(r, cyc);
        if (!exp_adef)
            check_data("o_resp.data", exp_data, r.data);
        check_adef("o_resp.adef", exp_adef, r.adef);
        check_addr("o_resp.addr", addr, r.addr);
        if (exp_lat > 0 && cyc - last_acc != exp_lat) begin
            n_other++;
            $display("response to %h came %0d cycles after acceptance instead of %0d",
                     addr, cyc - last_acc, exp_lat);
        end else if (exp_lat < 0 && cyc - mem_rdy_cyc != 1) begin
            n_other++;
            $display("response to %h came %0d cycles after the memory line instead of 1",
                     addr, cyc - mem_rdy_cyc);
        end
    endtask

    task automatic miss_then_hit();
        logic [31:0] base;
        line_t       line;
        fetch_resp_t r;
        int          cyc;
        int          prev;
        int          n0;
        int          c;
        base = 32'h0000_0100;
        line = u_mem.line_at(base);
        n0   = u_mem.req_count;
        fetch_check(base, FETCH, chunk_of(line, base), -1);
        for (c = 1; c < 8; c++)
            send(base + c * 8, FETCH);
        @(negedge clk);
        i_req_valid = 1'b0;
        for (c = 1; c < 8; c++) begin
            take_resp(r, cyc);
            check_data("o_resp.data", chunk_of(line, base + c * 8), r.data);
            check_addr("o_resp.addr", base + c * 8, r.addr);
            if (c > 1 && cyc != prev + 1) begin
                n_other++;
                $display("hit responses at %0t are not on consecutive cycles", $time);
            end
            prev = cyc;
        end
        check_count("memory requests", n0 + 1, u_mem.req_count);
    endtask

    task automatic misaligned();
        int n0;
        n0 = u_mem.req_count;
        fetch_check(32'h0000_0202, FETCH, '0, 1);
        check_count("memory requests", n0, u_mem.req_count);
    endtask

    task automatic uncached();
        logic [31:0] a;
        line_t       old;
        int          n0;
        a   = 32'h0000_0348;
        old = u_mem.line_at(a);
        fetch_check(a, FETCH, chunk_of(old, a), -1);
        check_addr("o_mem_req.addr", 32'h0000_0340, mem_addr);   // whole line
        u_mem.write_line(a, ~old);
        n0 = u_mem.req_count;
        fetch_check(a, FETCH_UNCACHED, chunk_of(~old, a), -1);
        check_count("memory requests", n0 + 1, u_mem.req_count);
        check_addr("o_mem_req.addr", 32'h0000_0348, mem_addr);   // one chunk
        fetch_check(a, FETCH, chunk_of(old, a), 1);   // cached copy untouched
        check_count("memory requests", n0 + 1, u_mem.req_count);
    endtask

    // after A, B and A again in one set C evicts B
    task automatic lru_replace();
        logic [31:0] a;
        logic [31:0] b;
        line_t       old_a;
        line_t       old_b;
        int          n0;
        a     = 32'h0000_1280;
        b     = 32'h0000_2280;
        old_a = u_mem.line_at(a);
        old_b = u_mem.line_at(b);
        fetch_check(a, FETCH, chunk_of(old_a, a), -1);
        fetch_check(b, FETCH, chunk_of(old_b, b), -1);
        fetch_check(a, FETCH, chunk_of(old_a, a), 1);
        fetch_check(32'h0000_3280, FETCH, chunk_of(u_mem.line_at(32'h0000_3280), 0), -1);
        u_mem.write_line(a, ~old_a);
        u_mem.write_line(b, ~old_b);
        u_mem.write_line(32'h0000_3280, ~u_mem.line_at(32'h0000_3280));
        n0 = u_mem.req_count;
        fetch_check(a, FETCH, chunk_of(old_a, a), 1);
        check_count("memory requests", n0, u_mem.req_count);
        fetch_check(b, FETCH, chunk_of(~old_b, b), -1);
        check_count("memory requests", n0 + 1, u_mem.req_count);
    endtask

    task automatic hit_invalidate();
        logic [31:0] a;
        line_t       old;
        int          n0;
        a   = 32'h0000_1410;
        old = u_mem.line_at(a);
        fetch_check(a, FETCH, chunk_of(old, a), -1);
        fetch_check(a, HIT_INV, '0, 2);
        u_mem.write_line(a, ~old);
        n0 = u_mem.req_count;
        fetch_check(a, FETCH, chunk_of(~old, a), -1);
        check_count("memory requests", n0 + 1, u_mem.req_count);
    endtask

    // in a fresh set the first fill lands in way 1 and the second in way 0
    task automatic index_invalidate(input logic [31:0] set_base, input logic way);
        logic [31:0] gone;
        logic [31:0] kept;
        line_t       old_gone;
        line_t       old_kept;
        int          n0;
        gone     = way ? set_base + 32'h1000 : set_base + 32'h2000;
        kept     = way ? set_base + 32'h2000 : set_base + 32'h1000;
        old_gone = u_mem.line_at(gone);
        old_kept = u_mem.line_at(kept);
        fetch_check(set_base + 32'h1000, FETCH, chunk_of(way ? old_gone : old_kept, 0), -1);
        fetch_check(set_base + 32'h2000, FETCH, chunk_of(way ? old_kept : old_gone, 0), -1);
        fetch_check({set_base[31:1], way}, IDX_INV, '0, 2);
        u_mem.write_line(gone, ~old_gone);
        u_mem.write_line(kept, ~old_kept);
        n0 = u_mem.req_count;
        fetch_check(kept, FETCH, chunk_of(old_kept, kept), 1);
        fetch_check(gone, FETCH, chunk_of(~old_gone, gone), -1);
        check_count("memory requests", n0 + 1, u_mem.req_count);
    endtask

    initial begin
        rstn        = 1'b0;
        i_req_valid = 1'b0;
        i_req       = '0;
        repeat (10) @(negedge clk);
        rstn = 1'b1;
        @(posedge clk);
        while (!o_req_ready) @(posedge clk);   // tag sweep first
        miss_then_hit();
        misaligned();
        uncached();
        lru_replace();
        hit_invalidate();
        index_invalidate(32'h0000_0440, 1'b1);
        index_invalidate(32'h0000_0480, 1'b0);
        repeat (5) @(negedge clk);
        if (resp_q.size() != 0) begin
            n_other++;
            $display("%0d responses arrived that no request asked for", resp_q.size());
        end
        $display("errors: %0d value mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch + n_other == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: icache_top.f
+incdir+common
common/icache_pkg.sv
icache/icache_sram.sv
icache/icache_hit_check.sv
icache/icache_read_align.sv
icache/icache_ctrl.sv
rtl/icache_top.sv
dv/tb_icache_mem.sv
dv/tb_icache.sv

// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - common

sources:
  - files:
      - common/icache_pkg.sv
      - icache/icache_sram.sv
      - icache/icache_hit_check.sv
      - icache/icache_read_align.sv
      - icache/icache_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    files:
      - dv/tb_icache_mem.sv
      - dv/tb_icache.sv
